// File: files.f
+incdir+hdl
hdl/ul_pack_pkg.sv
hdl/ul_frame_writer.sv
hdl/ul_pingpong_buffer.sv
hdl/ul_cpri_packer.sv
hdl/ul_pack_top.sv
testbench/ul_pack_asserts.sv
testbench/ul_pack_tb.sv

// File: Bender.yml
package:
  name: ul_pack

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ul_pack_pkg.sv
      - hdl/ul_frame_writer.sv
      - hdl/ul_pingpong_buffer.sv
      - hdl/ul_cpri_packer.sv
      - hdl/ul_pack_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/ul_pack_asserts.sv
      - testbench/ul_pack_tb.sv

// File: testbench/ul_pack_tb.sv
`timescale 1ns/1ps
`include "ul_pack_settings.svh"

module ul_pack_tb
    import ul_pack_pkg::*;
();

    localparam int NUM_PKTS    = 8;
    localparam int CYCLE_LIMIT = 120 * NUM_PKTS + 200;

    logic       clk;
    logic       rst;
    logic       i_vld;
    logic       i_sop;
    ant_beat_t  i_beat;
    cfg_in_t    i_cfg;
    logic       o_cpri_wen;
    beat_addr_t o_cpri_waddr;
    cpri_word_t o_cpri_wdata;
    logic       o_cpri_wlast;

    integer     seed;
    int         cyc;

    // packet being driven
    ant_beat_t  pkt_beats [`UL_PKT_LEN];
    cfg_in_t    pkt_cfg;

    // expected writes in output order
    beat_addr_t exp_addr_q [$];
    cpri_word_t exp_data_q [$];
    string      name_q [$];
    int         first_q [$];

    // comparison state
    int                     wr_idx;
    string                  cur_name;
    logic [`UL_PKT_LEN-1:0] seen;

    ul_pack_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .i_vld        (i_vld),
        .i_sop        (i_sop),
        .i_beat       (i_beat),
        .i_cfg        (i_cfg),
        .o_cpri_wen   (o_cpri_wen),
        .o_cpri_waddr (o_cpri_waddr),
        .o_cpri_wdata (o_cpri_wdata),
        .o_cpri_wlast (o_cpri_wlast)
    );

    always #4 clk = ~clk;

    // --------------------
    // reporting
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
            stop_with_error($sformatf("Error: %s expected %0h actual %0h",
                                      name, expected, actual));
    endtask

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT)
            stop_with_error($sformatf("Timeout: run went past %0d cycles", CYCLE_LIMIT));
    end

    // --------------------
    // expected writes of one packet
    function automatic void ref_packet(
        input  ant_beat_t  beats [`UL_PKT_LEN],
        input  cfg_in_t    cfg,
        output beat_addr_t addrs [`UL_PKT_LEN],
        output cpri_word_t words [`UL_PKT_LEN]
    );
        logic [63:0] hdr;
        logic [31:0] cur;
        logic [31:0] prv;
        logic [31:0] w;
        int          data_addr;
        int          g;
        int          e;
        hdr = {15'd0, cfg.rbg_idx, 5'd0, cfg.ch_type, cfg.prb_idx[7:0], cfg.cell_idx,
               cfg.slot_idx, cfg.sym_idx, cfg.info[7:4], 12'd0};
        data_addr = `UL_DATA_ADDR_FIRST;
        for (int i = 0; i < `UL_PKT_LEN; i++)
        begin
            g = i / `UL_GRP_LEN;
            e = i % `UL_GRP_LEN;
            words[i] = '0;
            if (e == 0)
            begin
                // leading slots first, the rest after the data words
                if (g < `UL_DATA_ADDR_FIRST)
                    addrs[i] = beat_addr_t'(g);
                else
                    addrs[i] = beat_addr_t'(`UL_PKT_LEN - `UL_NUM_GRP + g);
                if (g == 0)
                    words[i] = hdr;
                else if (g == `UL_NUM_GRP - 1)
                    words[i] = `UL_PKT_LEN - 1;
            end
            else
            begin
                for (int a = 0; a < `UL_NUM_ANT; a++)
                begin
                    cur = beats[i].ant[a];
                    prv = beats[i - 1].ant[a];
                    w   = (prv >> (2 * e - 2)) | (cur << (16 - 2 * e));
                    words[i][16 * a +: 16] = w[15:0];
                end
                addrs[i] = beat_addr_t'(data_addr);
                data_addr++;
            end
        end
    endfunction

    // --------------------
    // stimulus helpers
    function automatic ant_beat_t random_beat();
        ant_beat_t b;
        for (int a = 0; a < `UL_NUM_ANT; a++)
            b.ant[a] = sample_t'($random(seed));
        return b;
    endfunction

    function automatic cfg_in_t random_cfg();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return cfg_in_t'(r[36:0]);
    endfunction

    task automatic make_packet();
        for (int i = 0; i < `UL_PKT_LEN; i++)
            pkt_beats[i] = random_beat();
        pkt_cfg = random_cfg();
    endtask

    task automatic go_idle();
        i_vld  = 1'b0;
        i_sop  = 1'b0;
        i_beat = random_beat();
        @(negedge clk);
    endtask

    // called on a falling edge, returns on the one after the last beat
    task automatic drive_packet(input string name, input bit with_gaps);
        beat_addr_t ref_addr [`UL_PKT_LEN];
        cpri_word_t ref_data [`UL_PKT_LEN];
        ref_packet(pkt_beats, pkt_cfg, ref_addr, ref_data);
        for (int i = 0; i < `UL_PKT_LEN; i++)
        begin
            exp_addr_q.push_back(ref_addr[i]);
            exp_data_q.push_back(ref_data[i]);
        end
        name_q.push_back(name);
        for (int i = 0; i < `UL_PKT_LEN; i++)
        begin
            while (with_gaps && (($random(seed) & 7) == 0))
                go_idle();
            i_vld  = 1'b1;
            i_sop  = (i == 0);
            i_beat = pkt_beats[i];
            // cfg is junk away from sop
            i_cfg  = (i == 0) ? pkt_cfg : random_cfg();
            // taken on the next rising edge, first write 4 edges later
            if (i == `UL_PKT_LEN - 1)
                first_q.push_back(cyc + 5);
            @(negedge clk);
        end
    endtask

    task automatic wait_drained();
        while (exp_addr_q.size() != 0)
            @(negedge clk);
    endtask

    // --------------------
    // output comparison
    always @(negedge clk)
    begin
        if (!rst && o_cpri_wen === 1'b1)
        begin
            if (exp_addr_q.size() == 0 || (wr_idx == 0 && first_q.size() == 0))
                stop_with_error("A write came out before its packet was complete");
            if (wr_idx == 0)
            begin
                cur_name = name_q.pop_front();
                seen     = '0;
                check_value({cur_name, " first write cycle"}, first_q.pop_front(), cyc);
            end
            check_value($sformatf("%s addr %0d", cur_name, wr_idx),
                        exp_addr_q.pop_front(), o_cpri_waddr);
            check_value($sformatf("%s word %0d", cur_name, wr_idx),
                        exp_data_q.pop_front(), o_cpri_wdata);
            check_value($sformatf("%s wlast %0d", cur_name, wr_idx),
                        (wr_idx == `UL_PKT_LEN - 1), o_cpri_wlast);
            check_value({cur_name, " address repeat"}, 0, seen[o_cpri_waddr]);
            seen[o_cpri_waddr] = 1'b1;
            if (wr_idx == `UL_PKT_LEN - 1)
                wr_idx = 0;
            else
                wr_idx = wr_idx + 1;
        end
        else if (!rst && o_cpri_wlast === 1'b1)
            stop_with_error("o_cpri_wlast was high without o_cpri_wen");
    end

    // --------------------
    // test sequence
    initial
    begin
        seed   = 7673;
        clk    = 1'b0;
        rst    = 1'b1;
        i_vld  = 1'b0;
        i_sop  = 1'b0;
        i_beat = '0;
        i_cfg  = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // nothing may come out while idle
        repeat (10) @(negedge clk);

        make_packet();
        drive_packet("single packet", 1'b0);
        go_idle();
        wait_drained();

        // both banks busy at once
        for (int p = 0; p < 3; p++)
        begin
            make_packet();
            drive_packet("back to back", 1'b0);
        end

        for (int p = 0; p < 2; p++)
        begin
            make_packet();
            drive_packet("random gaps", 1'b1);
        end

        // same data with and without gaps
        make_packet();
        drive_packet("replay plain", 1'b0);
        drive_packet("replay gapped", 1'b1);
        go_idle();
        wait_drained();

        repeat (10) @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

// File: testbench/ul_pack_asserts.sv
`timescale 1ns/1ps
`include "ul_pack_settings.svh"

module ul_pack_asserts (
    input logic clk,
    input logic rst,
    input logic i_cpri_wen,
    input logic i_cpri_wlast
);

    // position of the current write within its packet
    logic [`UL_ADDR_W-1:0] run_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
            run_cnt <= '0;
        else if (i_cpri_wen)
            run_cnt <= i_cpri_wlast ? '0 : run_cnt + 1'b1;
    end

    wen_low_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !i_cpri_wen)
        else $error("write enable high during reset");

    wlast_with_wen: assert property (@(posedge clk) disable iff (rst)
        i_cpri_wlast |-> i_cpri_wen)
        else $error("last strobe without write enable");

    // --------------------
    // 96 writes per packet, runs may join back to back
    wlast_on_96th: assert property (@(posedge clk) disable iff (rst)
        i_cpri_wen |-> (i_cpri_wlast == (run_cnt == `UL_PKT_LEN - 1)))
        else $error("last strobe not on the 96th write");

    run_ends_on_wlast: assert property (@(posedge clk) disable iff (rst)
        $fell(i_cpri_wen) |-> $past(i_cpri_wlast))
        else $error("write run ended before the 96th write");

endmodule

bind ul_pack_top ul_pack_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .i_cpri_wen   (o_cpri_wen),
    .i_cpri_wlast (o_cpri_wlast)
);

// File: hdl/ul_pack_top.sv
`timescale 1ns/1ps
`include "ul_pack_settings.svh"

module ul_pack_top
    import ul_pack_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_vld,
    input  logic       i_sop,
    input  ant_beat_t  i_beat,
    input  cfg_in_t    i_cfg,
    output logic       o_cpri_wen,
    output beat_addr_t o_cpri_waddr,
    output cpri_word_t o_cpri_wdata,
    output logic       o_cpri_wlast
);

    // writer to buffer
    logic       wr_en;
    beat_addr_t wr_addr;
    ant_beat_t  wr_beat;
    pkt_hdr_t   wr_hdr;
    logic       wr_last;

    // buffer to packer
    logic       rd_start;
    beat_addr_t rd_addr;
    ant_beat_t  rd_beat;
    pkt_hdr_t   rd_hdr;

    ul_frame_writer u_writer (
        .clk       (clk),
        .rst       (rst),
        .i_vld     (i_vld),
        .i_sop     (i_sop),
        .i_beat    (i_beat),
        .i_cfg     (i_cfg),
        .o_wr_en   (wr_en),
        .o_wr_addr (wr_addr),
        .o_wr_beat (wr_beat),
        .o_wr_hdr  (wr_hdr),
        .o_wr_last (wr_last)
    );

    ul_pingpong_buffer u_buffer (
        .clk        (clk),
        .rst        (rst),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_beat  (wr_beat),
        .i_wr_hdr   (wr_hdr),
        .i_wr_last  (wr_last),
        .i_rd_addr  (rd_addr),
        .o_rd_start (rd_start),
        .o_rd_beat  (rd_beat),
        .o_rd_hdr   (rd_hdr)
    );

    ul_cpri_packer u_packer (
        .clk          (clk),
        .rst          (rst),
        .i_rd_start   (rd_start),
        .i_rd_beat    (rd_beat),
        .i_rd_hdr     (rd_hdr),
        .o_rd_addr    (rd_addr),
        .o_cpri_wen   (o_cpri_wen),
        .o_cpri_waddr (o_cpri_waddr),
        .o_cpri_wdata (o_cpri_wdata),
        .o_cpri_wlast (o_cpri_wlast)
    );

endmodule

// File: hdl/ul_cpri_packer.sv
`timescale 1ns/1ps
`include "ul_pack_settings.svh"

module ul_cpri_packer
    import ul_pack_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_rd_start,
    input  ant_beat_t  i_rd_beat,
    input  pkt_hdr_t   i_rd_hdr,
    output beat_addr_t o_rd_addr,
    output logic       o_cpri_wen,
    output beat_addr_t o_cpri_waddr,
    output cpri_word_t o_cpri_wdata,
    output logic       o_cpri_wlast
);

    localparam beat_addr_t LAST_BEAT  = beat_addr_t'(`UL_PKT_LEN - 1);
    localparam beat_addr_t DATA_FIRST = beat_addr_t'(`UL_DATA_ADDR_FIRST);
    localparam beat_addr_t DATA_LAST  = beat_addr_t'(`UL_DATA_ADDR_LAST);

    pack_state_t state;
    beat_addr_t  rd_cnt;
    logic        rd_req;

    // stage 1, aligned with the read data
    logic        vld_d1;
    beat_addr_t  addr_d1;
    re_idx_t     re_d1;
    grp_idx_t    grp_d1;
    ant_beat_t   prev_beat;
    word16_t [`UL_NUM_ANT-1:0] pack_word;

    // stage 2
    logic        vld_d2;
    logic        last_d2;
    re_idx_t     re_d2;
    grp_idx_t    grp_d2;
    cpri_word_t  slot_d2;
    word16_t [`UL_NUM_ANT-1:0] pack_d2;
    beat_addr_t  data_addr;

    // low 2k bits of cur above the top of prev
    function automatic word16_t pack_sample(sample_t cur, sample_t prev, re_idx_t k);
        logic [2*`UL_SAMPLE_W-1:0] pair;
        pair = {cur, prev};
        return word16_t'(pair >> (2 * k - 2));
    endfunction

    function automatic cpri_word_t slot_word(grp_idx_t g, pkt_hdr_t hdr);
        case (g)
            grp_idx_t'(0):               return cpri_word_t'(hdr);
            grp_idx_t'(`UL_NUM_GRP - 1): return cpri_word_t'(`UL_PKT_LEN - 1);
            default:                     return '0;
        endcase
    endfunction

    // slots fill 0..6, then 91..95
    function automatic beat_addr_t slot_addr(grp_idx_t g);
        if (g < `UL_DATA_ADDR_FIRST)
            return beat_addr_t'(g);
        return beat_addr_t'(g + `UL_DATA_ADDR_LAST + 1 - `UL_DATA_ADDR_FIRST);
    endfunction

    // --------------------
    // readout sequencing
    // address 0 is already on the bus in the start cycle
    assign rd_req    = (state == ST_RUN) || i_rd_start;
    assign o_rd_addr = rd_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= ST_IDLE;
            rd_cnt <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (i_rd_start)
                    begin
                        state  <= ST_RUN;
                        rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                ST_RUN:
                begin
                    if (rd_cnt == LAST_BEAT)
                    begin
                        state  <= ST_IDLE;
                        rd_cnt <= '0;
                    end
                    else
                        rd_cnt <= rd_cnt + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // --------------------
    // packing
    assign re_d1  = re_idx_t'(addr_d1 % `UL_GRP_LEN);
    assign grp_d1 = grp_idx_t'(addr_d1 / `UL_GRP_LEN);

    always_comb
    begin
        for (int a = 0; a < `UL_NUM_ANT; a++)
            pack_word[a] = pack_sample(i_rd_beat.ant[a], prev_beat.ant[a], re_d1);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            vld_d1 <= 1'b0;
            vld_d2 <= 1'b0;
        end
        else
        begin
            vld_d1 <= rd_req;
            vld_d2 <= vld_d1;
        end
    end

    always_ff @(posedge clk)
    begin
        addr_d1   <= rd_cnt;
        prev_beat <= i_rd_beat;
        pack_d2   <= pack_word;
        slot_d2   <= slot_word(grp_d1, i_rd_hdr);
        re_d2     <= re_d1;
        grp_d2    <= grp_d1;
        last_d2   <= (addr_d1 == LAST_BEAT);
    end

    // --------------------
    // output writes
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_cpri_wen   <= 1'b0;
            o_cpri_wlast <= 1'b0;
            data_addr    <= DATA_FIRST;
        end
        else
        begin
            o_cpri_wen   <= vld_d2;
            o_cpri_wlast <= vld_d2 && last_d2;
            if (!vld_d2)
                data_addr <= DATA_FIRST;
            else if (re_d2 != '0)
                data_addr <= (data_addr == DATA_LAST) ? DATA_FIRST : data_addr + 1'b1;
        end
    end

    // element 0 of each group carries the slot word
    always_ff @(posedge clk)
    begin
        if (re_d2 == '0)
        begin
            o_cpri_waddr <= slot_addr(grp_d2);
            o_cpri_wdata <= slot_d2;
        end
        else
        begin
            o_cpri_waddr <= data_addr;
            o_cpri_wdata <= pack_d2;
        end
    end

endmodule

// File: hdl/ul_pingpong_buffer.sv
`timescale 1ns/1ps
`include "ul_pack_settings.svh"

module ul_pingpong_buffer
    import ul_pack_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_wr_en,
    input  beat_addr_t i_wr_addr,
    input  ant_beat_t  i_wr_beat,
    input  pkt_hdr_t   i_wr_hdr,
    input  logic       i_wr_last,
    input  beat_addr_t i_rd_addr,
    output logic       o_rd_start,
    output ant_beat_t  o_rd_beat,
    output pkt_hdr_t   o_rd_hdr
);

    localparam beat_addr_t LAST_BEAT = beat_addr_t'(`UL_PKT_LEN - 1);

    // two banks of one packet each
    ant_beat_t  bank_mem [0:1][0:`UL_PKT_LEN-1];
    pkt_hdr_t   bank_hdr [0:1];

    logic       wr_bank;
    logic       rd_bank;
    logic [1:0] bank_full;
    logic       wr_done;
    logic       rd_done;

    assign wr_done = i_wr_en && i_wr_last;

    // the last read of a packet empties its bank
    assign rd_done = bank_full[rd_bank] && (i_rd_addr == LAST_BEAT);

    // --------------------
    // write side
    always_ff @(posedge clk)
    begin
        if (i_wr_en)
            bank_mem[wr_bank][i_wr_addr] <= i_wr_beat;
        // header is held by the writer until the last beat
        if (wr_done)
            bank_hdr[wr_bank] <= i_wr_hdr;
    end

    // --------------------
    // bank selects
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_bank    <= 1'b0;
            rd_bank    <= 1'b0;
            o_rd_start <= 1'b0;
        end
        else
        begin
            o_rd_start <= wr_done;
            if (wr_done)
            begin
                // filled bank goes to the reader, writer moves on
                wr_bank <= ~wr_bank;
                rd_bank <= wr_bank;
            end
        end
    end

    // full flags per bank
    always_ff @(posedge clk)
    begin
        if (rst)
            bank_full <= '0;
        else
        begin
            if (rd_done)
                bank_full[rd_bank] <= 1'b0;
            if (wr_done)
                bank_full[wr_bank] <= 1'b1;
        end
    end

    // --------------------
    // read side, one cycle latency
    always_ff @(posedge clk)
    begin
        // hold the last beat while no bank is being drained
        if (bank_full[rd_bank])
        begin
            o_rd_beat <= bank_mem[rd_bank][i_rd_addr];
            o_rd_hdr  <= bank_hdr[rd_bank];
        end
    end

endmodule

// File: hdl/ul_frame_writer.sv
`timescale 1ns/1ps
`include "ul_pack_settings.svh"

module ul_frame_writer
    import ul_pack_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_vld,
    input  logic       i_sop,
    input  ant_beat_t  i_beat,
    input  cfg_in_t    i_cfg,
    output logic       o_wr_en,
    output beat_addr_t o_wr_addr,
    output ant_beat_t  o_wr_beat,
    output pkt_hdr_t   o_wr_hdr,
    output logic       o_wr_last
);

    localparam beat_addr_t LAST_BEAT = beat_addr_t'(`UL_PKT_LEN - 1);

    beat_addr_t beat_cnt;
    beat_addr_t cur_addr;
    pkt_hdr_t   hdr_next;

    // sop realigns the count to the packet start
    assign cur_addr = i_sop ? '0 : beat_cnt;

    // --------------------
    // header word built from the sop config
    always_comb
    begin
        hdr_next          = '0;
        hdr_next.rbg_idx  = i_cfg.rbg_idx;
        hdr_next.ch_type  = i_cfg.ch_type;
        hdr_next.prb_lo   = i_cfg.prb_idx[7:0];
        hdr_next.cell_idx = i_cfg.cell_idx;
        hdr_next.slot_idx = i_cfg.slot_idx;
        hdr_next.sym_idx  = i_cfg.sym_idx;
        // only the upper info nibble of antenna 0 is kept
        hdr_next.info_hi  = i_cfg.info[7:4];
    end

    // --------------------
    // beat counter and strobes
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat_cnt  <= '0;
            o_wr_en   <= 1'b0;
            o_wr_last <= 1'b0;
        end
        else
        begin
            o_wr_en   <= i_vld;
            o_wr_last <= i_vld && (cur_addr == LAST_BEAT);
            if (i_vld)
                beat_cnt <= (cur_addr == LAST_BEAT) ? '0 : cur_addr + 1'b1;
        end
    end

    // beat payload and held header
    always_ff @(posedge clk)
    begin
        if (i_vld)
        begin
            o_wr_addr <= cur_addr;
            o_wr_beat <= i_beat;
        end
        if (i_vld && i_sop)
            o_wr_hdr <= hdr_next;
    end

endmodule

// File: hdl/ul_pack_pkg.sv
`include "ul_pack_settings.svh"

package ul_pack_pkg;

    // --------------------
    // plain vectors
    typedef logic [`UL_SAMPLE_W-1:0]             sample_t;
    typedef logic [`UL_WORD16_W-1:0]             word16_t;
    typedef logic [`UL_ADDR_W-1:0]               beat_addr_t;
    typedef logic [$clog2(`UL_GRP_LEN)-1:0]      re_idx_t;
    typedef logic [$clog2(`UL_NUM_GRP)-1:0]      grp_idx_t;
    typedef logic [`UL_CPRI_W-1:0]               cpri_word_t;

    // --------------------
    // one beat, antenna 0 in the low bits
    typedef struct packed {
        sample_t [`UL_NUM_ANT-1:0] ant;
    } ant_beat_t;

    // header word, exactly one output word wide
    typedef struct packed {
        logic [14:0] pad;
        logic [3:0]  rbg_idx;
        logic [4:0]  rsvd_a;
        logic [3:0]  ch_type;
        logic [7:0]  prb_lo;
        logic        cell_idx;
        logic [6:0]  slot_idx;
        logic [3:0]  sym_idx;
        logic [3:0]  info_hi;
        logic [11:0] rsvd_b;
    } pkt_hdr_t;

    // per-packet config, sampled at sop
    typedef struct packed {
        logic [3:0] ch_type;
        logic       cell_idx;
        logic [6:0] slot_idx;
        logic [3:0] sym_idx;
        logic [8:0] prb_idx;
        logic [7:0] info;
        logic [3:0] rbg_idx;
    } cfg_in_t;

    typedef enum logic {ST_IDLE, ST_RUN} pack_state_t;

endpackage

// File: hdl/ul_pack_settings.svh
`ifndef UL_PACK_SETTINGS_SVH
`define UL_PACK_SETTINGS_SVH

// sample and word widths
`define UL_SAMPLE_W        14
`define UL_WORD16_W        16
`define UL_CPRI_W          64
`define UL_NUM_ANT         4

// packet geometry, 12 groups of 8 elements
`define UL_PKT_LEN         96
`define UL_GRP_LEN         8
`define UL_NUM_GRP         12
`define UL_ADDR_W          7

// output address map
// data words sit between the two runs of slot words
`define UL_DATA_ADDR_FIRST 7
`define UL_DATA_ADDR_LAST  90

`endif
